//--- src/qla_pkg.sv
// shared widths and encodings; address decode covers only chan 7:4 and offset 3:0, bits 15:8 ignored
package qla_pkg;

    // ------------------------------
    // bus and field widths
    // ------------------------------
    localparam int REG_ADDR_W = 16;     // register address
    localparam int REG_DATA_W = 32;     // register data
    localparam int CUR_W      = 16;     // current command / feedback magnitude
    localparam int CHAN_W     = 4;      // channel field, 0 = board, 1..15 = axes
    localparam int OFF_W      = 4;      // offset field within a channel
    localparam int BOARD_ID_W = 4;      // rotary switch id

    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [REG_DATA_W-1:0] reg_data_t;
    typedef logic [CUR_W-1:0]      cur_t;
    typedef logic [CHAN_W-1:0]     chan_t;

    // address layout: addr[7:4] channel, addr[3:0] offset
    localparam int CHAN_LSB = 4;
    localparam int OFF_LSB  = 0;

    // status word: board id in 27:24, amp disable per axis in 1..NUM_CHAN
    localparam int STATUS_ID_LSB = 24;

    // ------------------------------
    // register offsets
    // ------------------------------
    typedef enum logic [OFF_W-1:0] {
        OFF_ADC_DATA = 4'd0,            // axis feedback readback
        OFF_DAC_CTRL = 4'd1             // axis command write / readback
    } reg_offset_e;

    // board channel reuses offset 0 for status / clear
    localparam reg_offset_e OFF_BOARD_STATUS = OFF_ADC_DATA;

    // per-axis safety latch
    typedef enum logic {
        SAFE_OK      = 1'b0,
        SAFE_TRIPPED = 1'b1
    } safety_state_e;

    // channel number out of a register address
    function automatic chan_t addr_chan(input reg_addr_t addr);
        return addr[CHAN_LSB +: CHAN_W];
    endfunction

    // offset field of a register address, as the enum
    function automatic reg_offset_e addr_off(input reg_addr_t addr);
        return reg_offset_e'(addr[OFF_LSB +: OFF_W]);
    endfunction

endpackage

//--- src/dac_cmd_regs.sv
// command regs for axes 1..NUM_CHAN; low 16 bits of wdata kept, upper bits dropped, no block writes
module dac_cmd_regs #(
    parameter int NUM_CHAN = 4              // axes present, 1..15
) (
    input  logic                               sysclk,
    input  logic                               reset,
    input  logic                               reg_wen,     // single-cycle write strobe
    input  qla_pkg::reg_addr_t                 reg_waddr,
    input  qla_pkg::reg_data_t                 reg_wdata,
    output logic [NUM_CHAN*qla_pkg::CUR_W-1:0] cur_cmd      // axis n in slice n-1
);

    // ------------------------------
    // write decode
    // ------------------------------
    qla_pkg::chan_t       wr_chan;      // channel field of write address
    qla_pkg::reg_offset_e wr_off;       // offset field of write address
    logic                 wr_dac;       // write aimed at a dac ctrl offset

    assign wr_chan = qla_pkg::addr_chan(reg_waddr);
    assign wr_off  = qla_pkg::addr_off(reg_waddr);
    assign wr_dac  = reg_wen && (wr_off == qla_pkg::OFF_DAC_CTRL);

    // ------------------------------
    // command storage
    // ------------------------------
    // new value visible the cycle after the write strobe
    always_ff @(posedge sysclk) begin
        if (reset) begin
            cur_cmd <= '0;                              // all axes commanded to zero
        end else begin
            for (int i = 0; i < NUM_CHAN; i++) begin
                // channel 0 never matches, it is the board channel
                if (wr_dac && (wr_chan == qla_pkg::chan_t'(i + 1))) begin
                    cur_cmd[i*qla_pkg::CUR_W +: qla_pkg::CUR_W] <=
                        reg_wdata[qla_pkg::CUR_W-1:0];  // low half only
                end
            end
        end
    end

endmodule

//--- src/adc_feedback_buf.sv
// feedback latch per axis; strobes for channel 0 or axes above NUM_CHAN are dropped silently
module adc_feedback_buf #(
    parameter int NUM_CHAN = 4              // axes present, 1..15
) (
    input  logic                               sysclk,
    input  logic                               reset,
    input  logic                               adc_strobe,  // one cycle per sample
    input  qla_pkg::chan_t                     adc_chan,    // axis the sample belongs to
    input  qla_pkg::cur_t                      adc_data,    // unsigned magnitude
    output logic [NUM_CHAN*qla_pkg::CUR_W-1:0] cur_fb,      // latest sample, axis n in n-1
    output logic [NUM_CHAN-1:0]                fb_update    // one-cycle pulse per new sample
);

    // ------------------------------
    // per-axis hit decode
    // ------------------------------
    logic [NUM_CHAN-1:0] hit;           // strobe lands on this axis

    always_comb begin
        hit = '0;
        for (int i = 0; i < NUM_CHAN; i++) begin
            hit[i] = adc_strobe && (adc_chan == qla_pkg::chan_t'(i + 1));
        end
    end

    // ------------------------------
    // sample store and update pulse
    // ------------------------------
    // both show up one cycle after the strobe, same cycle
    always_ff @(posedge sysclk) begin
        if (reset) begin
            cur_fb    <= '0;
            fb_update <= '0;
        end else begin
            fb_update <= hit;                           // drops again next cycle
            for (int i = 0; i < NUM_CHAN; i++) begin
                if (hit[i]) begin
                    cur_fb[i*qla_pkg::CUR_W +: qla_pkg::CUR_W] <= adc_data;
                end
            end
        end
    end

    // back-to-back strobes for different axes each get their own pulse,
    // the checker for the older axis still sees its held sample

endmodule

//--- src/safety_check.sv
// one axis over-current trip; trips after TRIP_COUNT samples with fb > 2*cmd, only a clear releases it
module safety_check #(
    parameter int TRIP_COUNT = 3            // consecutive violations to trip, >= 1
) (
    input  logic          sysclk,
    input  logic          reset,
    input  qla_pkg::cur_t cur_cmd,      // commanded current
    input  qla_pkg::cur_t cur_fb,       // latest feedback
    input  logic          fb_update,    // cur_fb is a fresh sample this cycle
    input  logic          safety_clear, // release the latch, wins over a trip
    output logic          amp_disable   // high while tripped
);

    localparam int CNT_W = $clog2(TRIP_COUNT + 1);

    qla_pkg::safety_state_e state;
    logic [CNT_W-1:0]       viol_cnt;   // consecutive over-current samples
    logic                   over_cur;   // this sample violates the limit
    logic                   last_viol;  // one more violation reaches TRIP_COUNT

    // ------------------------------
    // limit compare
    // ------------------------------
    // 17-bit compare so 2*cmd cannot wrap; equal to 2*cmd is safe
    assign over_cur  = {1'b0, cur_fb} > {cur_cmd, 1'b0};
    assign last_viol = (viol_cnt == CNT_W'(TRIP_COUNT - 1));

    // ------------------------------
    // trip FSM and counter
    // ------------------------------
    always_ff @(posedge sysclk) begin
        if (reset) begin
            state    <= qla_pkg::SAFE_OK;
            viol_cnt <= '0;
        end else if (safety_clear) begin
            state    <= qla_pkg::SAFE_OK;       // clear beats a same-cycle trip
            viol_cnt <= '0;                     // fresh run of violations needed
        end else begin
            case (state)
                qla_pkg::SAFE_OK: begin
                    if (fb_update) begin
                        if (over_cur) begin
                            viol_cnt <= viol_cnt + 1'b1;    // tops out at TRIP_COUNT
                            if (last_viol) begin
                                state <= qla_pkg::SAFE_TRIPPED;
                            end
                        end else begin
                            viol_cnt <= '0;                 // run broken
                        end
                    end
                end
                qla_pkg::SAFE_TRIPPED: begin
                    // latched, counter frozen until cleared
                end
                default: begin
                    state <= qla_pkg::SAFE_OK;
                end
            endcase
        end
    end

    // straight from the state register, strobe + 2 cycles
    assign amp_disable = (state == qla_pkg::SAFE_TRIPPED);

endmodule

//--- src/board_status_regs.sv
// registered read mux, 1-cycle latency; unmapped offsets and channels above NUM_CHAN read 0
module board_status_regs #(
    parameter int NUM_CHAN = 4              // axes present, 1..15
) (
    input  logic                               sysclk,
    input  logic                               reset,
    input  logic [qla_pkg::BOARD_ID_W-1:0]     board_id,
    input  logic                               reg_wen,
    input  qla_pkg::reg_addr_t                 reg_waddr,
    input  qla_pkg::reg_data_t                 reg_wdata,
    input  qla_pkg::reg_addr_t                 reg_raddr,   // new address every cycle
    input  logic [NUM_CHAN*qla_pkg::CUR_W-1:0] cur_cmd,
    input  logic [NUM_CHAN*qla_pkg::CUR_W-1:0] cur_fb,
    input  logic [NUM_CHAN-1:0]                amp_disable,
    output qla_pkg::reg_data_t                 reg_rdata,
    output logic [NUM_CHAN-1:0]                safety_clear // one pulse bit per axis
);

    // ------------------------------
    // status word
    // ------------------------------
    qla_pkg::reg_data_t status_word;

    always_comb begin
        status_word = '0;                                   // bit 0 and spares stay 0
        status_word[qla_pkg::STATUS_ID_LSB +: qla_pkg::BOARD_ID_W] = board_id;
        status_word[NUM_CHAN:1] = amp_disable;              // axis n at bit n
    end

    // ------------------------------
    // read select
    // ------------------------------
    qla_pkg::chan_t       rd_chan;
    qla_pkg::reg_offset_e rd_off;
    qla_pkg::reg_data_t   rd_next;      // value for reg_rdata next cycle

    assign rd_chan = qla_pkg::addr_chan(reg_raddr);
    assign rd_off  = qla_pkg::addr_off(reg_raddr);

    always_comb begin
        rd_next = '0;
        if (rd_chan == '0) begin
            if (rd_off == qla_pkg::OFF_BOARD_STATUS) begin
                rd_next = status_word;
            end
        end else begin
            for (int i = 0; i < NUM_CHAN; i++) begin
                if (rd_chan == qla_pkg::chan_t'(i + 1)) begin
                    case (rd_off)
                        qla_pkg::OFF_ADC_DATA:                  // feedback, zero-extended
                            rd_next = qla_pkg::reg_data_t'(cur_fb[i*qla_pkg::CUR_W +:
                                                                  qla_pkg::CUR_W]);
                        qla_pkg::OFF_DAC_CTRL:                  // command, zero-extended
                            rd_next = qla_pkg::reg_data_t'(cur_cmd[i*qla_pkg::CUR_W +:
                                                                   qla_pkg::CUR_W]);
                        default: rd_next = '0;
                    endcase
                end
            end
        end
    end

    // ------------------------------
    // clear decode
    // ------------------------------
    logic status_wr;                    // write to board status register

    assign status_wr = reg_wen && (qla_pkg::addr_chan(reg_waddr) == '0) &&
                       (qla_pkg::addr_off(reg_waddr) == qla_pkg::OFF_BOARD_STATUS);

    always_ff @(posedge sysclk) begin
        if (reset) begin
            reg_rdata    <= '0;
            safety_clear <= '0;
        end else begin
            reg_rdata    <= rd_next;                            // previous cycle's address
            safety_clear <= status_wr ? reg_wdata[NUM_CHAN:1] : '0;    // wdata bit n, axis n
        end
    end

endmodule

//--- src/qla_safety_top.sv
// current-loop safety slice on sysclk; register bus is plain strobes with no back-pressure
module qla_safety_top #(
    parameter int NUM_CHAN   = 4,           // axes present, 1..15
    parameter int TRIP_COUNT = 3            // consecutive violations to trip
) (
    input  logic                           sysclk,
    input  logic                           reset,       // sync, active high
    input  logic [qla_pkg::BOARD_ID_W-1:0] board_id,
    // register bus
    input  logic                           reg_wen,
    input  qla_pkg::reg_addr_t             reg_waddr,
    input  qla_pkg::reg_data_t             reg_wdata,
    input  qla_pkg::reg_addr_t             reg_raddr,
    output qla_pkg::reg_data_t             reg_rdata,
    // adc feedback, parallel
    input  logic                           adc_strobe,
    input  qla_pkg::chan_t                 adc_chan,
    input  qla_pkg::cur_t                  adc_data,
    // amp enables, axis n at bit n-1
    output logic [NUM_CHAN-1:0]            amp_disable
);

    logic [NUM_CHAN*qla_pkg::CUR_W-1:0] cur_cmd;    // dac commands, flattened
    logic [NUM_CHAN*qla_pkg::CUR_W-1:0] cur_fb;     // adc feedback, flattened
    logic [NUM_CHAN-1:0]                fb_update;
    logic [NUM_CHAN-1:0]                safety_clear;

    // ------------------------------
    // commands and feedback
    // ------------------------------
    dac_cmd_regs #(.NUM_CHAN(NUM_CHAN)) u_dac_cmd_regs (
        .sysclk    (sysclk),
        .reset     (reset),
        .reg_wen   (reg_wen),
        .reg_waddr (reg_waddr),
        .reg_wdata (reg_wdata),
        .cur_cmd   (cur_cmd)
    );

    adc_feedback_buf #(.NUM_CHAN(NUM_CHAN)) u_adc_feedback_buf (
        .sysclk     (sysclk),
        .reset      (reset),
        .adc_strobe (adc_strobe),
        .adc_chan   (adc_chan),
        .adc_data   (adc_data),
        .cur_fb     (cur_fb),
        .fb_update  (fb_update)
    );

    // board channel: status, clear, read mux
    board_status_regs #(.NUM_CHAN(NUM_CHAN)) u_board_status_regs (
        .sysclk       (sysclk),
        .reset        (reset),
        .board_id     (board_id),
        .reg_wen      (reg_wen),
        .reg_waddr    (reg_waddr),
        .reg_wdata    (reg_wdata),
        .reg_raddr    (reg_raddr),
        .cur_cmd      (cur_cmd),
        .cur_fb       (cur_fb),
        .amp_disable  (amp_disable),
        .reg_rdata    (reg_rdata),
        .safety_clear (safety_clear)
    );

    // ------------------------------
    // one checker per axis
    // ------------------------------
    for (genvar i = 0; i < NUM_CHAN; i++) begin : g_axis
        safety_check #(.TRIP_COUNT(TRIP_COUNT)) u_safety_check (
            .sysclk       (sysclk),
            .reset        (reset),
            .cur_cmd      (cur_cmd[i*qla_pkg::CUR_W +: qla_pkg::CUR_W]),
            .cur_fb       (cur_fb[i*qla_pkg::CUR_W +: qla_pkg::CUR_W]),
            .fb_update    (fb_update[i]),
            .safety_clear (safety_clear[i]),
            .amp_disable  (amp_disable[i])
        );
    end

endmodule

//--- testbench/qla_tb_tasks.svh
// bus and adc drive tasks for tb_qla_safety; each case line takes exactly one clock
`ifndef QLA_TB_TASKS_SVH
`define QLA_TB_TASKS_SVH

// compare and count, report on mismatch
task automatic check_value(input string name, input logic [31:0] got,
                           input logic [31:0] expected);
    checks++;
    if (got !== expected) begin
        errors++;
        $display("** Error at time %0t: %s = %h, expected %h", $time, name, got, expected);
    end
endtask

// ------------------------------
// per-cycle drive
// ------------------------------
// outputs are registered, so sampling right after the edge is safe
task automatic step_begin();
    @(posedge sysclk);
    #1;                                     // drive a little after the edge
    if (rd_pending) begin
        check_value("reg_rdata", reg_rdata, rd_expect);
        rd_pending = 1'b0;
    end
    reg_wen    = 1'b0;                      // strobes last a single cycle
    adc_strobe = 1'b0;
endtask

task automatic write_reg(input logic [15:0] addr, input logic [31:0] data);
    reg_wen   = 1'b1;
    reg_waddr = addr;
    reg_wdata = data;
endtask

task automatic issue_read(input logic [15:0] addr, input logic [31:0] expected);
    reg_raddr  = addr;
    rd_expect  = expected;                  // compared at the next step
    rd_pending = 1'b1;
endtask

task automatic send_sample(input logic [3:0] chan, input logic [15:0] data);
    adc_strobe = 1'b1;
    adc_chan   = chan;
    adc_data   = data;
endtask

// one case line, one clock
task automatic run_case(input byte op, input logic [15:0] addr,
                        input logic [31:0] data, input logic [31:0] expected);
    step_begin();
    case (op)
        "W": write_reg(addr, data);
        "A": send_sample(addr[3:0], data[15:0]);
        "R": issue_read(addr, expected);
        "M": check_value("amp_disable", {28'd0, amp_disable}, expected);
        "I": begin
            // bus quiet for a cycle
        end
        default: begin
            errors++;
            $display("unknown operation %c in the case file", op);
        end
    endcase
endtask

`endif

//--- testbench/tb_qla_safety.sv
// runs from the project root, reads testbench/qla_cases.txt; DUT at default parameters (4 axes, trip after 3)
module tb_qla_safety;

    localparam string CASE_FILE = "testbench/qla_cases.txt";
    localparam int    RESET_CYCLES = 16;

    // ------------------------------
    // DUT signals
    // ------------------------------
    logic                 sysclk;
    logic                 reset;
    logic [3:0]           board_id;
    logic                 reg_wen;
    qla_pkg::reg_addr_t   reg_waddr;
    qla_pkg::reg_data_t   reg_wdata;
    qla_pkg::reg_addr_t   reg_raddr;
    qla_pkg::reg_data_t   reg_rdata;
    logic                 adc_strobe;
    qla_pkg::chan_t       adc_chan;
    qla_pkg::cur_t        adc_data;
    logic [3:0]           amp_disable;      // axis n at bit n-1

    // case table, one entry per data line
    byte                  case_op[$];
    logic [15:0]          case_addr[$];
    logic [31:0]          case_data[$];
    logic [31:0]          case_exp[$];

    int                   checks = 0;
    int                   errors = 0;
    int                   cycles = 0;
    int                   cycle_limit = 100;    // raised once the cases are loaded

    logic                 rd_pending;       // read issued last step
    logic [31:0]          rd_expect;        // value due on reg_rdata this step

    `include "qla_tb_tasks.svh"

    // ------------------------------
    // clock and DUT
    // ------------------------------
    initial sysclk = 1'b0;
    always #4 sysclk = ~sysclk;             // period 8

    qla_safety_top u_qla_safety_top (
        .sysclk      (sysclk),
        .reset       (reset),
        .board_id    (board_id),
        .reg_wen     (reg_wen),
        .reg_waddr   (reg_waddr),
        .reg_wdata   (reg_wdata),
        .reg_raddr   (reg_raddr),
        .reg_rdata   (reg_rdata),
        .adc_strobe  (adc_strobe),
        .adc_chan    (adc_chan),
        .adc_data    (adc_data),
        .amp_disable (amp_disable)
    );

    // pull every data line of the case file into the queues
    task automatic load_cases(output bit ok);
        int          fd;
        int          fields;
        string       line;
        byte         op;
        logic [31:0] addr_f;
        logic [31:0] data_f;
        logic [31:0] exp_f;
        fd = $fopen(CASE_FILE, "r");
        ok = (fd != 0);
        if (ok) begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                fields = $sscanf(line, "%c %h %h %h", op, addr_f, data_f, exp_f);
                if ((fields == 4) && (op != "#")) begin    // comments and blanks fall out here
                    case_op.push_back(op);
                    case_addr.push_back(addr_f[15:0]);
                    case_data.push_back(data_f);
                    case_exp.push_back(exp_f);
                end
            end
            $fclose(fd);
        end
    endtask

    // ------------------------------
    // cycle counter
    // ------------------------------
    initial begin
        while (cycles < cycle_limit) begin
            @(posedge sysclk);
            cycles++;
        end
        $display("timeout, the cases did not finish within %0d cycles", cycle_limit);
        $display("Verification failed");
        $finish;
    end

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin
        bit loaded;
        reset      = 1'b1;
        board_id   = 4'ha;                  // shows up in status bits 27:24
        reg_wen    = 1'b0;
        reg_waddr  = '0;
        reg_wdata  = '0;
        reg_raddr  = '0;
        adc_strobe = 1'b0;
        adc_chan   = '0;
        adc_data   = '0;
        rd_pending = 1'b0;
        rd_expect  = '0;
        load_cases(loaded);
        if (!loaded) begin
            $display("cannot open the case file %s", CASE_FILE);
            $display("Verification failed");
            $finish;
        end else begin
            cycle_limit = 20 * case_op.size() + 100;
            repeat (RESET_CYCLES) @(posedge sysclk);
            #1;
            reset = 1'b0;
            foreach (case_op[i]) begin
                run_case(case_op[i], case_addr[i], case_data[i], case_exp[i]);
            end
            step_begin();                   // picks up a read issued by the last line
            $display("checks: %0d, errors: %0d", checks, errors);
            if (errors == 0) begin
                $display("Verification passed");
            end else begin
                $display("Verification failed");
            end
            $finish;
        end
    end

endmodule

//--- testbench/qla_cases.txt
# op addr_or_chan data expect, all hex; W write, A adc strobe, R read, M amp_disable, I idle
# one line per clock; R is compared on the next line, a trip shows 2 lines after its strobe
M 0000 00000000 00000000
R 0000 00000000 0a000000
R 0010 00000000 00000000
R 0011 00000000 00000000
R 0001 00000000 00000000
R 0050 00000000 00000000
W 0011 abcd1234 00000000
R 0011 00000000 00001234
W 0021 00000100 00000000
W 0031 00000080 00000000
W 0041 0000ffff 00000000
R 0021 00000000 00000100
R 0031 00000000 00000080
R 0041 00000000 0000ffff
R 0012 00000000 00000000
A 0001 00000555 00000000
R 0010 00000000 00000555
A 0000 00007777 00000000
A 0005 00007777 00000000
R 0010 00000000 00000555
R 0020 00000000 00000000
M 0000 00000000 00000000
# axis 2 trips, limit 0x200
A 0002 00000201 00000000
A 0002 0000ffff 00000000
A 0002 00000201 00000000
M 0000 00000000 00000000
M 0000 00000000 00000002
R 0000 00000000 0a000004
A 0002 00000000 00000000
I 0000 00000000 00000000
M 0000 00000000 00000002
# axis 3 run broken by a sample equal to the limit 0x100
A 0003 00000101 00000000
A 0003 00000150 00000000
A 0003 00000100 00000000
A 0003 00000101 00000000
A 0003 00000101 00000000
I 0000 00000000 00000000
M 0000 00000000 00000002
A 0003 00000200 00000000
M 0000 00000000 00000002
M 0000 00000000 00000006
# clear axes 1 2 4, only 2 is tripped
W 0000 00000016 00000000
M 0000 00000000 00000006
M 0000 00000000 00000004
R 0000 00000000 0a000008
A 0002 00000201 00000000
A 0002 00000201 00000000
I 0000 00000000 00000000
I 0000 00000000 00000000
M 0000 00000000 00000004
A 0002 00000300 00000000
M 0000 00000000 00000004
M 0000 00000000 00000006
# clear drops a partial run on axis 1, limit 0x2468
A 0001 00003000 00000000
A 0001 00003000 00000000
I 0000 00000000 00000000
W 0000 00000002 00000000
I 0000 00000000 00000000
I 0000 00000000 00000000
A 0001 00003000 00000000
I 0000 00000000 00000000
I 0000 00000000 00000000
M 0000 00000000 00000006
R 0000 00000000 0a00000c
R 0010 00000000 00003000

//--- tb.f
+incdir+testbench
src/qla_pkg.sv
src/dac_cmd_regs.sv
src/adc_feedback_buf.sv
src/safety_check.sv
src/board_status_regs.sv
src/qla_safety_top.sv
testbench/tb_qla_safety.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds tb_qla_safety with Verilator (5.x, --timing) and runs it from the project root.

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "cannot enter the project root"
    exit 1
fi

verilator --binary --timing --top-module tb_qla_safety -f tb.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_qla_safety)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Verification passed"; then
    exit 0
fi
exit 1
